/* hdl/beatmap_pkg.sv */
package beatmap_pkg;

    typedef enum logic [2:0] {
        UP,
        RIGHT,
        DOWN,
        LEFT,
        ANY                                 // any slash direction counts
    } block_direction_t;

    typedef enum logic [0:0] {
        BLUE,
        RED
    } block_color_t;

    localparam int BLOCK_POS_W   = 12;
    localparam int BLOCK_TIME_W  = 18;      // same width as the song clock
    localparam int BLOCK_INDEX_W = 8;

    typedef struct packed {
        logic [BLOCK_POS_W-1:0]  x;
        logic [BLOCK_POS_W-1:0]  y;
        logic [BLOCK_TIME_W-1:0] due_time; // song tick the block reaches the player
        block_color_t            color;
        block_direction_t        direction;
    } block_t;

    localparam int MAP_LENGTH = 8;
    localparam int MAP_SEL_W  = $clog2(MAP_LENGTH);

    // one block every 100 ticks, first one due at tick 200
    localparam block_t BEAT_MAP [MAP_LENGTH] = '{
        '{12'd200, 12'd200, 18'd200, RED,  UP},
        '{12'd300, 12'd200, 18'd300, BLUE, RIGHT},
        '{12'd400, 12'd200, 18'd400, BLUE, DOWN},
        '{12'd500, 12'd200, 18'd500, RED,  LEFT},
        '{12'd600, 12'd200, 18'd600, RED,  ANY},
        '{12'd700, 12'd200, 18'd700, BLUE, UP},
        '{12'd800, 12'd200, 18'd800, BLUE, RIGHT},
        '{12'd900, 12'd200, 18'd900, RED,  DOWN}
    };

    localparam int QUEUE_DEPTH   = 4;       // power of two, pointers wrap freely
    localparam int QUEUE_PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_W = QUEUE_PTR_W + 1;

endpackage

/* hdl/song_timing_pkg.sv */
package song_timing_pkg;

    localparam int SONG_TIME_W = 18;

    // song clock prescaler
    localparam int TICK_CYCLES = 8;
    localparam int TICK_W      = $clog2(TICK_CYCLES);

    // ticks from spawn until the block reaches the player
    localparam int TRAVEL_TICKS = 99;

    // half width of the hit window in ticks
    localparam int HIT_WINDOW = 10;

    typedef enum logic [1:0] {
        HIT,
        WRONG,                              // wrong colour or direction
        MISS                                // window closed without a swing
    } judge_kind_t;

    localparam int HIT_SCORE = 100;
    localparam int SCORE_W   = 16;

endpackage

/* hdl/block_if.sv */
`timescale 1ns/10ps

interface block_if import beatmap_pkg::*; ();

    logic                     valid;
    logic [BLOCK_INDEX_W-1:0] index;
    block_t                   block;
    logic                     advance;     // one-cycle consume pulse from the sink

    modport source (
        output valid,
        output index,
        output block,
        input  advance
    );

    modport sink (
        input  valid,
        input  index,
        input  block,
        output advance
    );

endinterface

/* hdl/song_clock.sv */
`timescale 1ns/10ps

module song_clock import song_timing_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   run,
    output logic [SONG_TIME_W-1:0] song_time
);

    logic [TICK_W-1:0] prescale;
    logic              tick;

    assign tick = (prescale == TICK_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in || !run) begin
            prescale  <= '0;               // song restarts from zero
            song_time <= '0;
        end else begin
            if (tick) begin
                prescale  <= '0;
                song_time <= song_time + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // the song never runs backwards while it plays
    time_monotonic: assert property (
        @(posedge clk_in) disable iff (rst_in)
        run && $past(run) |-> song_time >= $past(song_time)
    );

endmodule

/* hdl/block_loader.sv */
`timescale 1ns/10ps

module block_loader import beatmap_pkg::*; (
    input  logic    clk_in,
    input  logic    rst_in,
    block_if.source map_bus
);

    logic [BLOCK_INDEX_W-1:0] next_index;
    logic                     last_entry;

    assign next_index = map_bus.index + 1'b1;
    assign last_entry = (map_bus.index == BLOCK_INDEX_W'(MAP_LENGTH - 1));

    // registered table read, later a BRAM port
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            map_bus.index <= '0;
            map_bus.valid <= 1'b1;          // entry 0 ready right after reset
            map_bus.block <= BEAT_MAP[0];
        end else if (map_bus.valid && map_bus.advance) begin
            if (last_entry) begin
                map_bus.valid <= 1'b0;      // map exhausted and stays low
            end else begin
                map_bus.index <= next_index;
                map_bus.block <= BEAT_MAP[next_index[MAP_SEL_W-1:0]];
            end
        end
    end

    // the sink only consumes a block that is shown
    advance_when_valid: assert property (
        @(posedge clk_in) disable iff (rst_in)
        map_bus.advance |-> map_bus.valid
    );

endmodule

/* hdl/block_queue.sv */
`timescale 1ns/10ps

module block_queue import beatmap_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     push,
    input  logic [BLOCK_INDEX_W-1:0] push_index,
    input  block_t                   push_block,
    output logic                     queue_full,
    output logic                     queue_empty,
    block_if.source                  head_bus
);

    block_t                   block_mem [QUEUE_DEPTH];
    logic [BLOCK_INDEX_W-1:0] index_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0]   wr_ptr;
    logic [QUEUE_PTR_W-1:0]   rd_ptr;
    logic [QUEUE_COUNT_W-1:0] count;
    logic                     do_push;
    logic                     do_pop;

    assign queue_empty = (count == '0);
    assign queue_full  = (count == QUEUE_COUNT_W'(QUEUE_DEPTH));

    assign do_push = push && !queue_full;
    assign do_pop  = head_bus.advance && !queue_empty;

    // oldest entry is always on the head bus
    assign head_bus.valid = !queue_empty;
    assign head_bus.index = index_mem[rd_ptr];
    assign head_bus.block = block_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            block_mem[wr_ptr] <= push_block;
            index_mem[wr_ptr] <= push_index;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    no_push_full: assert property (
        @(posedge clk_in) disable iff (rst_in) push |-> !queue_full
    );

    no_pop_empty: assert property (
        @(posedge clk_in) disable iff (rst_in) head_bus.advance |-> !queue_empty
    );

endmodule

/* hdl/hit_judge.sv */
`timescale 1ns/10ps

module hit_judge
    import beatmap_pkg::*;
    import song_timing_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic [SONG_TIME_W-1:0]   song_time,
    input  logic                     swing_valid,
    input  block_direction_t         swing_direction,
    input  block_color_t             swing_color,
    block_if.sink                    head_bus,
    output logic                     judge_valid,
    output judge_kind_t              judge_kind,
    output logic [BLOCK_INDEX_W-1:0] judge_index,
    output logic [SCORE_W-1:0]       score
);

    logic [SONG_TIME_W:0] head_time;        // one spare bit against wrap
    logic [SONG_TIME_W:0] now_time;
    logic                 expired;
    logic                 window_open;
    logic                 swing_taken;
    logic                 match;
    logic                 pop;

    assign head_time = {1'b0, head_bus.block.due_time};
    assign now_time  = {1'b0, song_time};

    assign expired     = head_bus.valid &&
                         (head_time + (SONG_TIME_W + 1)'(HIT_WINDOW) < now_time);
    assign window_open = (now_time + (SONG_TIME_W + 1)'(HIT_WINDOW) >= head_time);

    // expiry wins over a swing in the same cycle
    assign swing_taken = swing_valid && head_bus.valid && !expired && window_open;

    assign match = (swing_color == head_bus.block.color) &&
                   ((swing_direction == head_bus.block.direction) ||
                    (head_bus.block.direction == ANY));

    assign pop              = expired || swing_taken;
    assign head_bus.advance = pop;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            judge_valid <= 1'b0;
            score       <= '0;
        end else begin
            judge_valid <= pop;
            if (swing_taken && match) begin
                score <= score + SCORE_W'(HIT_SCORE);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop) begin
            judge_index <= head_bus.index;
            if (expired)    judge_kind <= MISS;
            else if (match) judge_kind <= HIT;
            else            judge_kind <= WRONG;
        end
    end

    // back-to-back judgments never retire the same block twice
    one_pop_per_block: assert property (
        @(posedge clk_in) disable iff (rst_in)
        judge_valid && $past(judge_valid) |-> judge_index != $past(judge_index)
    );

endmodule

/* hdl/beatmap_ctrl.sv */
`timescale 1ns/10ps

module beatmap_ctrl
    import beatmap_pkg::*;
    import song_timing_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     start,
    input  logic [SONG_TIME_W-1:0]   song_time,
    block_if.sink                    map_bus,
    input  logic                     queue_full,
    input  logic                     queue_empty,
    output logic                     push,
    output logic                     run,
    output logic                     spawn_valid,
    output logic [BLOCK_INDEX_W-1:0] spawn_index,
    output block_t                   spawn_block,
    output logic                     done
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } ctrl_state_t;

    ctrl_state_t          state;
    logic [SONG_TIME_W:0] spawn_time;       // time at which the block may leave
    logic [SONG_TIME_W:0] now_time;
    logic                 spawn_due;

    // song_time plus travel against due time avoids underflow
    assign now_time   = {1'b0, song_time} + (SONG_TIME_W + 1)'(TRAVEL_TICKS);
    assign spawn_time = {1'b0, map_bus.block.due_time};
    assign spawn_due  = map_bus.valid && (now_time >= spawn_time);

    assign push            = (state == RUN) && spawn_due && !queue_full;
    assign map_bus.advance = push;

    assign run  = (state != IDLE);          // song keeps running in DONE
    assign done = (state == DONE);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) state <= RUN;
                end
                RUN: begin
                    // map exhausted and every block judged
                    if (!map_bus.valid && queue_empty) state <= DONE;
                end
                DONE:    state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            spawn_valid <= 1'b0;
        end else begin
            spawn_valid <= push;
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            spawn_index <= map_bus.index;
            spawn_block <= map_bus.block;
        end
    end

    // no block left to spawn or judge once done
    nothing_after_done: assert property (
        @(posedge clk_in) disable iff (rst_in)
        done |-> !map_bus.valid && queue_empty
    );

endmodule

/* hdl/beat_game_top.sv */
`timescale 1ns/10ps

module beat_game_top
    import beatmap_pkg::*;
    import song_timing_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     start,
    input  logic                     swing_valid,
    input  block_direction_t         swing_direction,
    input  block_color_t             swing_color,
    output logic                     spawn_valid,
    output logic [BLOCK_INDEX_W-1:0] spawn_index,
    output logic [BLOCK_POS_W-1:0]   spawn_x,
    output logic [BLOCK_POS_W-1:0]   spawn_y,
    output logic [BLOCK_TIME_W-1:0]  spawn_time,
    output block_color_t             spawn_color,
    output block_direction_t         spawn_direction,
    output logic [SONG_TIME_W-1:0]   song_time,
    output logic                     judge_valid,
    output judge_kind_t              judge_kind,
    output logic [BLOCK_INDEX_W-1:0] judge_index,
    output logic [SCORE_W-1:0]       score,
    output logic                     done
);

    logic   run;
    logic   push;
    logic   queue_full;
    logic   queue_empty;
    block_t spawn_block;

    block_if map_bus ();                    // loader to controller
    block_if head_bus ();                   // queue head to judge

    song_clock song_clock_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .run       (run),
        .song_time (song_time)
    );

    block_loader block_loader_i (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .map_bus (map_bus.source)
    );

    beatmap_ctrl beatmap_ctrl_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .start       (start),
        .song_time   (song_time),
        .map_bus     (map_bus.sink),
        .queue_full  (queue_full),
        .queue_empty (queue_empty),
        .push        (push),
        .run         (run),
        .spawn_valid (spawn_valid),
        .spawn_index (spawn_index),
        .spawn_block (spawn_block),
        .done        (done)
    );

    block_queue block_queue_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .push        (push),
        .push_index  (map_bus.index),
        .push_block  (map_bus.block),
        .queue_full  (queue_full),
        .queue_empty (queue_empty),
        .head_bus    (head_bus.source)
    );

    hit_judge hit_judge_i (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .song_time       (song_time),
        .swing_valid     (swing_valid),
        .swing_direction (swing_direction),
        .swing_color     (swing_color),
        .head_bus        (head_bus.sink),
        .judge_valid     (judge_valid),
        .judge_kind      (judge_kind),
        .judge_index     (judge_index),
        .score           (score)
    );

    assign spawn_x         = spawn_block.x;
    assign spawn_y         = spawn_block.y;
    assign spawn_time      = spawn_block.due_time;
    assign spawn_color     = spawn_block.color;
    assign spawn_direction = spawn_block.direction;

endmodule

/* test/beat_game_tb.sv */
`timescale 1ns/10ps

module beat_game_tb
    import beatmap_pkg::*;
    import song_timing_pkg::*;
();

    logic                     clk_in;
    logic                     rst_in;
    logic                     start;
    logic                     swing_valid;
    block_direction_t         swing_direction;
    block_color_t             swing_color;
    logic                     spawn_valid;
    logic [BLOCK_INDEX_W-1:0] spawn_index;
    logic [BLOCK_POS_W-1:0]   spawn_x;
    logic [BLOCK_POS_W-1:0]   spawn_y;
    logic [BLOCK_TIME_W-1:0]  spawn_time;
    block_color_t             spawn_color;
    block_direction_t         spawn_direction;
    logic [SONG_TIME_W-1:0]   song_time;
    logic                     judge_valid;
    judge_kind_t              judge_kind;
    logic [BLOCK_INDEX_W-1:0] judge_index;
    logic [SCORE_W-1:0]       score;
    logic                     done;

    int                       error_count    = 0;
    int                       check_count    = 0;
    int                       judge_count    = 0;
    int                       hit_count      = 0;
    integer                   seed           = 32'h3a24_d18b;
    logic [31:0]              rand_bits;
    logic [SCORE_W-1:0]       expected_score = '0;
    block_t                   spawn_seen;
    block_t                   spawn_blocks [$];
    logic [BLOCK_INDEX_W-1:0] spawn_indexes [$];
    logic [SONG_TIME_W-1:0]   spawn_times [$];

    beat_game_top dut_i (.*);

    assign spawn_seen = {spawn_x, spawn_y, spawn_time, spawn_color, spawn_direction};

    always #5 clk_in = ~clk_in;

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_index(input string name, input logic [BLOCK_INDEX_W-1:0] actual,
                               input logic [BLOCK_INDEX_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_time(input string name, input logic [SONG_TIME_W-1:0] actual,
                              input logic [SONG_TIME_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_score(input string name, input logic [SCORE_W-1:0] actual,
                               input logic [SCORE_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_kind(input string name, input judge_kind_t actual,
                              input judge_kind_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %s, expected %s", $time, name, actual.name(),
                     expected.name());
        end
    endtask

    task automatic check_block(input string name, input block_t actual, input block_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // spawn strobes and judgment pulses sampled away from the clock edge
    always @(negedge clk_in) begin
        if (!rst_in && spawn_valid) begin
            spawn_blocks.push_back(spawn_seen);
            spawn_indexes.push_back(spawn_index);
            spawn_times.push_back(song_time);
        end
        if (!rst_in && judge_valid) judge_count++;
    end

    task automatic wait_song_time(input int target);
        while (int'(song_time) < target) @(negedge clk_in);
    endtask

    task automatic swing_at(input int target, input block_direction_t dir,
                            input block_color_t color);
        wait_song_time(target);
        @(posedge clk_in);
        #1;
        swing_valid     = 1'b1;
        swing_direction = dir;
        swing_color     = color;
        @(posedge clk_in);
        #1 swing_valid = 1'b0;                      // one-cycle swing
    endtask

    task automatic judged_as(input int i, input judge_kind_t kind, input int limit);
        int n;
        n = 0;
        while (judge_valid !== 1'b1 && n < limit) begin
            @(negedge clk_in);
            n++;
        end
        if (judge_valid !== 1'b1) begin
            error_count++;
            $display("No judgment for block %0d within %0d cycles", i, limit);
        end else begin
            check_kind("judge_kind", judge_kind, kind);
            check_index("judge_index", judge_index, BLOCK_INDEX_W'(i));
        end
        check_score("score", score, expected_score);
        @(negedge clk_in);                          // step past the pulse
    endtask

    task automatic idle_after_reset();
        repeat (3) begin
            @(negedge clk_in);
            check_flag("spawn_valid", spawn_valid, 1'b0);
            check_flag("judge_valid", judge_valid, 1'b0);
            check_flag("done", done, 1'b0);
            check_score("score", score, '0);
            check_time("song_time", song_time, '0);
        end
    endtask

    task automatic start_song();
        @(posedge clk_in);
        #1 start = 1'b1;
        @(posedge clk_in);
        #1 start = 1'b0;
    endtask

    task automatic hit_block(input int i, input block_direction_t dir);
        swing_at(int'(BEAT_MAP[i].due_time), dir, BEAT_MAP[i].color);
        expected_score += SCORE_W'(HIT_SCORE);
        hit_count++;
        judged_as(i, HIT, 4);
    endtask

    task automatic wrong_swing(input int i, input block_direction_t dir,
                               input block_color_t color, input int offset);
        swing_at(int'(BEAT_MAP[i].due_time) + offset, dir, color);
        judged_as(i, WRONG, 4);
    endtask

    task automatic early_swing(input int i);
        swing_at(int'(BEAT_MAP[i].due_time) - HIT_WINDOW - 5, BEAT_MAP[i].direction,
                 BEAT_MAP[i].color);
        repeat (4) begin
            @(negedge clk_in);
            check_flag("judge_valid", judge_valid, 1'b0);   // window still closed
        end
    endtask

    task automatic missed_block(input int i);
        wait_song_time(int'(BEAT_MAP[i].due_time));
        judged_as(i, MISS, (HIT_WINDOW + 3) * TICK_CYCLES);
        check_count++;
        if (int'(song_time) <= int'(BEAT_MAP[i].due_time) + HIT_WINDOW) begin
            error_count++;
            $display("Block %0d was missed at song time %0d, before its window closed",
                     i, song_time);
        end
    endtask

    task automatic song_completion();
        int n;
        n = 0;
        while (done !== 1'b1 && n < 8) begin
            @(negedge clk_in);
            n++;
        end
        repeat (20) begin
            @(negedge clk_in);
            check_flag("done", done, 1'b1);         // held once reached
        end
        check_score("final score", score, SCORE_W'(HIT_SCORE * hit_count));
        check_count++;
        if (judge_count != MAP_LENGTH) begin
            error_count++;
            $display("Saw %0d judgments, expected one per map block (%0d)",
                     judge_count, MAP_LENGTH);
        end
    endtask

    task automatic spawn_schedule();
        check_count++;
        if (spawn_blocks.size() != MAP_LENGTH) begin
            error_count++;
            $display("Saw %0d spawns, expected %0d", spawn_blocks.size(), MAP_LENGTH);
        end
        for (int i = 0; i < MAP_LENGTH && i < spawn_blocks.size(); i++) begin
            check_index("spawn_index", spawn_indexes[i], BLOCK_INDEX_W'(i));
            check_block("spawn block", spawn_blocks[i], BEAT_MAP[i]);
            check_time("song_time at spawn", spawn_times[i],
                       SONG_TIME_W'(int'(BEAT_MAP[i].due_time) - TRAVEL_TICKS));
        end
    endtask

    // whole song plus travel and window with margin
    initial begin : watchdog
        int limit;
        limit = (int'(BEAT_MAP[MAP_LENGTH-1].due_time) + TRAVEL_TICKS + 2 * HIT_WINDOW)
                * TICK_CYCLES * 3;
        repeat (limit) @(posedge clk_in);
        $display("Run stopped by the watchdog after %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk_in          = 1'b0;
        rst_in          = 1'b1;
        start           = 1'b0;
        swing_valid     = 1'b0;
        swing_direction = UP;
        swing_color     = BLUE;
        rand_bits       = $random(seed);
        repeat (5) @(posedge clk_in);
        #1 rst_in = 1'b0;

        idle_after_reset();
        start_song();
        hit_block(0, UP);
        wrong_swing(1, RIGHT, RED, 0);              // colour mismatch
        early_swing(2);
        hit_block(2, DOWN);
        wrong_swing(3, UP, RED, -5);                // direction mismatch
        hit_block(4, block_direction_t'({1'b0, rand_bits[1:0]}));  // ANY block
        missed_block(5);
        hit_block(6, RIGHT);
        missed_block(7);
        song_completion();
        spawn_schedule();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/beatmap_pkg.sv
hdl/song_timing_pkg.sv
hdl/block_if.sv
hdl/song_clock.sv
hdl/block_loader.sv
hdl/block_queue.sv
hdl/hit_judge.sv
hdl/beatmap_ctrl.sv
hdl/beat_game_top.sv
test/beat_game_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module beat_game_tb -f sim.f -o beat_game_sim

./obj_dir/beat_game_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
